// File: collision/saved_boundary_check.sv
`timescale 1ns/1ns

module saved_boundary_check
(
    input  tetris_pkg::pos_t   block_x_pos,
    input  tetris_pkg::pos_t   block_y_pos,
    input  tetris_pkg::pos_t   bottom1, bottom2, bottom3, bottom4,
    input  tetris_pkg::pos_t   left1, left2, left3, left4,
    input  tetris_pkg::pos_t   right1, right2, right3, right4,
    input  tetris_pkg::board_t savedblocks,
    input  logic               is_currentstate,
    output logic               bottomchecked,
    output logic               leftchecked,
    output logic               rightchecked
);

    tetris_pkg::pos_t bot [4];
    tetris_pkg::pos_t lft [4];
    tetris_pkg::pos_t rgt [4];
    logic [3:0]       b_ok;
    logic [3:0]       l_ok;
    logic [3:0]       r_ok;
    int               base_col;
    int               row_a;
    int               row_b;
    int               cell_row;
    int               lc;
    int               rc;

    function automatic logic vacant(input tetris_pkg::board_t map, input int row, input int col);
        if (row < 0 || row >= (int'(tetris_pkg::floor_px) + 1) / tetris_pkg::cell_px)
            return 1'b0; // anything below the floor counts as filled
        if (col < 0 || col >= tetris_pkg::board_cols)
            return 1'b0;
        return !map[row * tetris_pkg::board_cols + col];
    endfunction

    assign bot = '{bottom1, bottom2, bottom3, bottom4};
    assign lft = '{left1, left2, left3, left4};
    assign rgt = '{right1, right2, right3, right4};

    always_comb
    begin
        base_col = int'(block_x_pos) / tetris_pkg::cell_px
                   - tetris_pkg::margin_px / tetris_pkg::cell_px;
        row_a    = int'(block_y_pos) / tetris_pkg::cell_px;
        row_b    = (int'(block_y_pos) + 14) / tetris_pkg::cell_px; // second sample point
        for (int k = 0; k < 4; k++)
        begin
            cell_row = int'(bot[k]) / tetris_pkg::cell_px;
            if (bot[k] == tetris_pkg::no_cell)
                b_ok[k] = 1'b1;
            else if (bot[k] >= tetris_pkg::floor_px)
                b_ok[k] = 1'b0;
            else
                b_ok[k] = vacant(savedblocks, cell_row, base_col + k)
                          && vacant(savedblocks, cell_row + 1, base_col + k);

            lc = int'(lft[k]) / tetris_pkg::cell_px - tetris_pkg::margin_px / tetris_pkg::cell_px;
            if (lft[k] == tetris_pkg::no_cell)
                l_ok[k] = 1'b1;
            else if (lft[k] < (is_currentstate ? tetris_pkg::left_limit_move
                                               : tetris_pkg::left_limit_state))
                l_ok[k] = 1'b0;
            else if (is_currentstate)
                l_ok[k] = vacant(savedblocks, row_a + k, lc - 1)
                          && vacant(savedblocks, row_b + k, lc - 1); // cell to the left
            else
                l_ok[k] = vacant(savedblocks, row_a + k, lc);

            rc = int'(rgt[k]) / tetris_pkg::cell_px - tetris_pkg::margin_px / tetris_pkg::cell_px;
            if (rgt[k] == tetris_pkg::no_cell)
                r_ok[k] = 1'b1;
            else if (rgt[k] > (is_currentstate ? tetris_pkg::right_limit_move
                                               : tetris_pkg::right_limit_state))
                r_ok[k] = 1'b0;
            else if (is_currentstate)
                r_ok[k] = vacant(savedblocks, row_a + k, rc + 1)
                          && vacant(savedblocks, row_b + k, rc + 1); // cell to the right
            else
                r_ok[k] = vacant(savedblocks, row_a + k, rc);
        end
        bottomchecked = &b_ok;
        leftchecked   = &l_ok;
        rightchecked  = &r_ok;
    end

endmodule

// File: common/tetris_pkg.sv
package tetris_pkg;

    localparam int cell_px    = 20;
    localparam int board_cols = 10;
    localparam int board_rows = 24;
    localparam int board_bits = board_cols * board_rows; // bit index is row * 10 + column
    localparam int margin_px  = 80;

    typedef logic [9:0]            pos_t;
    typedef logic [2:0]            piece_type_t; // I, O, T, S, Z, J, L
    typedef logic [1:0]            rot_t;
    typedef logic [board_bits-1:0] board_t;

    localparam pos_t floor_px          = 10'd459; // bottom pixel of row 22
    localparam pos_t left_limit_move   = 10'd100;
    localparam pos_t left_limit_state  = 10'd80;
    localparam pos_t right_limit_move  = 10'd259;
    localparam pos_t right_limit_state = 10'd279;
    localparam pos_t no_cell           = 10'd1023;
    localparam pos_t spawn_x           = 10'd140;
    localparam pos_t spawn_y           = 10'd0;

    // 4x4 frame masks, bit index is frame row * 4 + frame column
    localparam logic [15:0] shape_table [0:6][0:3] = '{
        '{16'h00F0, 16'h4444, 16'h0F00, 16'h2222},
        '{16'h0066, 16'h0066, 16'h0066, 16'h0066},
        '{16'h0072, 16'h0262, 16'h0270, 16'h0232},
        '{16'h0036, 16'h0462, 16'h0360, 16'h0231},
        '{16'h0063, 16'h0264, 16'h0630, 16'h0132},
        '{16'h0071, 16'h0226, 16'h0470, 16'h0322},
        '{16'h0074, 16'h0622, 16'h0170, 16'h0223}
    };

    // board cells covered by a piece, cells off the board are dropped
    function automatic board_t piece_mask(input piece_type_t kind, input rot_t rot,
                                          input pos_t x, input pos_t y);
        board_t      m;
        logic [15:0] s;
        int          row;
        int          col;
        m = '0;
        s = shape_table[kind][rot];
        for (int k = 0; k < 16; k++)
        begin
            row = int'(y) / cell_px + k / 4;
            col = int'(x) / cell_px - margin_px / cell_px + k % 4;
            if (s[k] && row < board_rows && col >= 0 && col < board_cols)
                m[row * board_cols + col] = 1'b1;
        end
        return m;
    endfunction

    // full rows vanish and everything above slides down
    function automatic board_t compact_rows(input board_t b);
        board_t res;
        int     dst;
        res = '0;
        dst = board_rows - 1;
        for (int r = board_rows - 1; r >= 0; r--)
        begin
            if (b[r * board_cols +: board_cols] != '1)
            begin
                res[dst * board_cols +: board_cols] = b[r * board_cols +: board_cols];
                dst = dst - 1;
            end
        end
        return res;
    endfunction

    function automatic logic [2:0] count_full(input board_t b);
        logic [2:0] n;
        n = '0;
        for (int r = 0; r < board_rows; r++)
        begin
            if (&b[r * board_cols +: board_cols])
                n = n + 3'd1;
        end
        return n;
    endfunction

endpackage

// File: src/drop_control.sv
`timescale 1ns/1ns

module drop_control
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    move_left,
    input  logic                    move_right,
    input  logic                    rotate,
    input  logic                    drop_tick,
    input  tetris_pkg::piece_type_t next_type,
    input  logic                    bottom_ok,
    input  logic                    left_ok,
    input  logic                    right_ok,
    input  logic                    rot_left_ok,
    input  logic                    rot_right_ok,
    input  tetris_pkg::board_t      board,
    output tetris_pkg::piece_type_t piece_type,
    output tetris_pkg::rot_t        piece_rot,
    output tetris_pkg::pos_t        piece_x,
    output tetris_pkg::pos_t        piece_y,
    output logic                    lock,
    output logic                    locked,
    output logic                    game_over
);

    tetris_pkg::board_t after_lock;
    logic               spawn_hit;

    assign lock = drop_tick && !bottom_ok && !game_over; // piece has landed

    always_comb
    begin
        after_lock = tetris_pkg::compact_rows(board
                     | tetris_pkg::piece_mask(piece_type, piece_rot, piece_x, piece_y));
        spawn_hit  = |(after_lock & tetris_pkg::piece_mask(next_type, '0,
                                                           tetris_pkg::spawn_x,
                                                           tetris_pkg::spawn_y));
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            piece_type <= '0;
            piece_rot  <= '0;
            piece_x    <= tetris_pkg::spawn_x;
            piece_y    <= tetris_pkg::spawn_y;
            locked     <= 1'b0;
            game_over  <= 1'b0;
        end
        else
        begin
            locked <= lock;
            if (lock)
            begin
                piece_type <= next_type;
                piece_rot  <= '0;
                piece_x    <= tetris_pkg::spawn_x;
                piece_y    <= tetris_pkg::spawn_y;
                if (spawn_hit)
                    game_over <= 1'b1; // sticky until reset
            end
            else if (!game_over)
            begin
                // one strobe acts per cycle, a refused one still blocks the rest
                if (drop_tick)
                    piece_y <= piece_y + tetris_pkg::pos_t'(tetris_pkg::cell_px);
                else if (rotate)
                begin
                    if (rot_left_ok && rot_right_ok)
                        piece_rot <= piece_rot + 2'd1;
                end
                else if (move_left)
                begin
                    if (left_ok)
                        piece_x <= piece_x - tetris_pkg::pos_t'(tetris_pkg::cell_px);
                end
                else if (move_right && right_ok)
                    piece_x <= piece_x + tetris_pkg::pos_t'(tetris_pkg::cell_px);
            end
        end
    end

endmodule

// File: src/piece_edges.sv
`timescale 1ns/1ns

module piece_edges
(
    input  tetris_pkg::piece_type_t piece_type,
    input  tetris_pkg::rot_t        piece_rot,
    input  tetris_pkg::pos_t        piece_x,
    input  tetris_pkg::pos_t        piece_y,
    output tetris_pkg::pos_t        bottom1, bottom2, bottom3, bottom4,
    output tetris_pkg::pos_t        left1, left2, left3, left4,
    output tetris_pkg::pos_t        right1, right2, right3, right4
);

    logic [15:0]      shape;
    tetris_pkg::pos_t bot [4];
    tetris_pkg::pos_t lft [4];
    tetris_pkg::pos_t rgt [4];

    always_comb
    begin
        shape = tetris_pkg::shape_table[piece_type][piece_rot];
        for (int j = 0; j < 4; j++)
        begin
            lft[j] = tetris_pkg::no_cell;
            rgt[j] = tetris_pkg::no_cell;
            bot[j] = tetris_pkg::no_cell;
            for (int i = 3; i >= 0; i--)
            begin
                if (shape[j * 4 + i])
                    lft[j] = piece_x + tetris_pkg::pos_t'(i * tetris_pkg::cell_px); // last hit is leftmost
            end
            for (int i = 0; i < 4; i++)
            begin
                if (shape[j * 4 + i])
                    rgt[j] = piece_x + tetris_pkg::pos_t'((i + 1) * tetris_pkg::cell_px - 1);
                if (shape[i * 4 + j])
                    bot[j] = piece_y + tetris_pkg::pos_t'((i + 1) * tetris_pkg::cell_px - 1);
            end
        end
    end

    assign bottom1 = bot[0];
    assign bottom2 = bot[1];
    assign bottom3 = bot[2];
    assign bottom4 = bot[3];
    assign left1   = lft[0];
    assign left2   = lft[1];
    assign left3   = lft[2];
    assign left4   = lft[3];
    assign right1  = rgt[0];
    assign right2  = rgt[1];
    assign right3  = rgt[2];
    assign right4  = rgt[3];

endmodule

// File: src/saved_board.sv
`timescale 1ns/1ns

module saved_board
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    lock,
    input  tetris_pkg::piece_type_t piece_type,
    input  tetris_pkg::rot_t        piece_rot,
    input  tetris_pkg::pos_t        piece_x,
    input  tetris_pkg::pos_t        piece_y,
    output tetris_pkg::board_t      board,
    output logic [2:0]              rows_cleared
);

    tetris_pkg::board_t merged;

    assign merged = board | tetris_pkg::piece_mask(piece_type, piece_rot, piece_x, piece_y);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            board        <= '0;
            rows_cleared <= '0;
        end
        else
        begin
            rows_cleared <= '0; // only meaningful in the cycle after a lock
            if (lock)
            begin
                board        <= tetris_pkg::compact_rows(merged);
                rows_cleared <= tetris_pkg::count_full(merged);
            end
        end
    end

endmodule

// File: src/tetris_core.sv
`timescale 1ns/1ns

module tetris_core
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    move_left,
    input  logic                    move_right,
    input  logic                    rotate,
    input  logic                    drop_tick,
    input  tetris_pkg::piece_type_t next_type,
    output tetris_pkg::board_t      board,
    output tetris_pkg::piece_type_t piece_type,
    output tetris_pkg::rot_t        piece_rot,
    output tetris_pkg::pos_t        piece_x,
    output tetris_pkg::pos_t        piece_y,
    output logic                    locked,
    output logic [2:0]              rows_cleared,
    output logic                    game_over
);

    tetris_pkg::pos_t now_b1, now_b2, now_b3, now_b4;
    tetris_pkg::pos_t now_l1, now_l2, now_l3, now_l4;
    tetris_pkg::pos_t now_r1, now_r2, now_r3, now_r4;
    tetris_pkg::pos_t rot_b1, rot_b2, rot_b3, rot_b4;
    tetris_pkg::pos_t rot_l1, rot_l2, rot_l3, rot_l4;
    tetris_pkg::pos_t rot_r1, rot_r2, rot_r3, rot_r4;
    logic             bottom_ok, left_ok, right_ok, rot_left_ok, rot_right_ok;
    logic             lock;

    piece_edges u_edges_now
    (
        .piece_type(piece_type), .piece_rot(piece_rot), .piece_x(piece_x), .piece_y(piece_y),
        .bottom1(now_b1), .bottom2(now_b2), .bottom3(now_b3), .bottom4(now_b4),
        .left1(now_l1), .left2(now_l2), .left3(now_l3), .left4(now_l4),
        .right1(now_r1), .right2(now_r2), .right3(now_r3), .right4(now_r4)
    );

    saved_boundary_check u_check_now
    (
        .block_x_pos(piece_x), .block_y_pos(piece_y),
        .bottom1(now_b1), .bottom2(now_b2), .bottom3(now_b3), .bottom4(now_b4),
        .left1(now_l1), .left2(now_l2), .left3(now_l3), .left4(now_l4),
        .right1(now_r1), .right2(now_r2), .right3(now_r3), .right4(now_r4),
        .savedblocks(board), .is_currentstate(1'b1),
        .bottomchecked(bottom_ok), .leftchecked(left_ok), .rightchecked(right_ok)
    );

    piece_edges u_edges_rot
    (
        .piece_type(piece_type), .piece_rot(piece_rot + 2'd1), // candidate rotation
        .piece_x(piece_x), .piece_y(piece_y),
        .bottom1(rot_b1), .bottom2(rot_b2), .bottom3(rot_b3), .bottom4(rot_b4),
        .left1(rot_l1), .left2(rot_l2), .left3(rot_l3), .left4(rot_l4),
        .right1(rot_r1), .right2(rot_r2), .right3(rot_r3), .right4(rot_r4)
    );

    saved_boundary_check u_check_rot
    (
        .block_x_pos(piece_x), .block_y_pos(piece_y),
        .bottom1(rot_b1), .bottom2(rot_b2), .bottom3(rot_b3), .bottom4(rot_b4),
        .left1(rot_l1), .left2(rot_l2), .left3(rot_l3), .left4(rot_l4),
        .right1(rot_r1), .right2(rot_r2), .right3(rot_r3), .right4(rot_r4),
        .savedblocks(board), .is_currentstate(1'b0),
        .bottomchecked(), .leftchecked(rot_left_ok), .rightchecked(rot_right_ok)
    );

    drop_control u_control
    (
        .clk(clk), .rst(rst),
        .move_left(move_left), .move_right(move_right), .rotate(rotate), .drop_tick(drop_tick),
        .next_type(next_type),
        .bottom_ok(bottom_ok), .left_ok(left_ok), .right_ok(right_ok),
        .rot_left_ok(rot_left_ok), .rot_right_ok(rot_right_ok),
        .board(board),
        .piece_type(piece_type), .piece_rot(piece_rot), .piece_x(piece_x), .piece_y(piece_y),
        .lock(lock), .locked(locked), .game_over(game_over)
    );

    saved_board u_board
    (
        .clk(clk), .rst(rst), .lock(lock),
        .piece_type(piece_type), .piece_rot(piece_rot), .piece_x(piece_x), .piece_y(piece_y),
        .board(board), .rows_cleared(rows_cleared)
    );

endmodule

// File: tb/tb_tetris_model.svh
`ifndef TB_TETRIS_MODEL_SVH
`define TB_TETRIS_MODEL_SVH

function automatic bit cell_free(input tetris_pkg::board_t b, input int row, input int col);
    if (row < 0 || row > int'(tetris_pkg::floor_px) / tetris_pkg::cell_px)
        return 1'b0; // below the floor counts as filled
    if (col < 0 || col >= tetris_pkg::board_cols)
        return 1'b0;
    return !b[row * tetris_pkg::board_cols + col];
endfunction

// side 0 is bottom, 1 is left, 2 is right
function automatic bit side_ok(input tetris_pkg::board_t b, input tetris_pkg::piece_type_t t,
                               input tetris_pkg::rot_t r, input int x, input int y,
                               input int side, input bit current);
    logic [15:0] s;
    int          lo;
    int          hi;
    int          e;
    int          c;
    bit          ok;
    s  = tetris_pkg::shape_table[t][r];
    ok = 1'b1;
    for (int j = 0; j < 4; j++)
    begin
        lo = -1;
        hi = -1;
        for (int i = 0; i < 4; i++)
        begin
            if ((side == 0) ? s[i * 4 + j] : s[j * 4 + i])
            begin
                if (lo < 0)
                    lo = i;
                hi = i;
            end
        end
        if (lo >= 0 && side == 0)
        begin
            e = y + 20 * (hi + 1) - 1;
            c = x / 20 - 4 + j;
            if (e >= 459)
                ok = 0;
            else
                ok = ok && cell_free(b, e / 20, c) && cell_free(b, e / 20 + 1, c);
        end
        else if (lo >= 0)
        begin
            e = (side == 1) ? x + 20 * lo : x + 20 * hi + 19;
            c = e / 20 - 4;
            if (current)
            begin
                c = (side == 1) ? c - 1 : c + 1; // the cell beside the edge
                if ((side == 1 && e < 100) || (side == 2 && e > 259))
                    ok = 0;
                else
                    ok = ok && cell_free(b, y / 20 + j, c) && cell_free(b, (y + 14) / 20 + j, c);
            end
            else if ((side == 1 && e < 80) || (side == 2 && e > 279))
                ok = 0;
            else
                ok = ok && cell_free(b, y / 20 + j, c);
        end
    end
    return ok;
endfunction

function automatic tetris_pkg::board_t cells_of(input tetris_pkg::piece_type_t t,
                                                input tetris_pkg::rot_t r, input int x, input int y);
    tetris_pkg::board_t m;
    logic [15:0]        s;
    int                 row;
    int                 col;
    m = '0;
    s = tetris_pkg::shape_table[t][r];
    for (int k = 0; k < 16; k++)
    begin
        row = y / 20 + k / 4;
        col = x / 20 - 4 + k % 4;
        if (s[k] && row < 24 && col >= 0 && col < 10)
            m[row * 10 + col] = 1'b1;
    end
    return m;
endfunction

function automatic void predict_step(inout tetris_pkg::board_t b,
                                     inout tetris_pkg::piece_type_t t, inout tetris_pkg::rot_t r,
                                     inout tetris_pkg::pos_t x, inout tetris_pkg::pos_t y,
                                     output bit lk, output logic [2:0] rc, inout bit go,
                                     input bit drop, input bit rot, input bit ml, input bit mr,
                                     input tetris_pkg::piece_type_t nt);
    tetris_pkg::board_t m;
    int                 dst;
    lk = 0;
    rc = 0;
    if (go)
        return;
    if (drop && side_ok(b, t, r, x, y, 0, 1))
        y = y + 20;
    else if (drop)
    begin
        m   = b | cells_of(t, r, x, y);
        b   = '0;
        dst = 23;
        for (int row = 23; row >= 0; row--)
        begin
            if (m[row * 10 +: 10] == 10'h3FF)
                rc = rc + 1;
            else
            begin
                b[dst * 10 +: 10] = m[row * 10 +: 10];
                dst--;
            end
        end
        lk = 1;
        t  = nt;
        r  = 0;
        x  = 140;
        y  = 0;
        go = |(b & cells_of(nt, 0, 140, 0));
    end
    else if (rot)
    begin
        if (side_ok(b, t, r + 2'd1, x, y, 1, 0) && side_ok(b, t, r + 2'd1, x, y, 2, 0))
            r = r + 2'd1;
    end
    else if (ml && side_ok(b, t, r, x, y, 1, 1))
        x = x - 20;
    else if (!ml && mr && side_ok(b, t, r, x, y, 2, 1))
        x = x + 20;
endfunction

task automatic check_board(input string name, input tetris_pkg::board_t got,
                           input tetris_pkg::board_t exp);
    if (got !== exp)
    begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_pos(input string name, input tetris_pkg::pos_t got, input tetris_pkg::pos_t exp);
    if (got !== exp)
    begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_type(input string name, input tetris_pkg::piece_type_t got,
                          input tetris_pkg::piece_type_t exp);
    if (got !== exp)
    begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_rot(input string name, input tetris_pkg::rot_t got, input tetris_pkg::rot_t exp);
    if (got !== exp)
    begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_count(input string name, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp)
    begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input bit exp);
    if (got !== exp)
    begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %0b expected %0b", $time, name, got, exp);
    end
endtask

`endif

// File: tb/tb_tetris_core.sv
`timescale 1ns/1ns

module tb_tetris_core;

    localparam int directed_cycles = 400;
    localparam int random_cycles   = 6000;
    localparam int cycle_limit     = directed_cycles + random_cycles + 100;

    logic clk, rst, move_left, move_right, rotate, drop_tick;
    tetris_pkg::piece_type_t next_type;
    tetris_pkg::board_t      board;
    tetris_pkg::piece_type_t piece_type;
    tetris_pkg::rot_t        piece_rot;
    tetris_pkg::pos_t        piece_x, piece_y;
    logic                    locked, game_over;
    logic [2:0]              rows_cleared;

    tetris_pkg::board_t      m_board, exp_board;
    tetris_pkg::piece_type_t m_type;
    tetris_pkg::rot_t        m_rot;
    tetris_pkg::pos_t        m_x, m_y;
    bit                      m_locked, m_go, prev_drop;
    logic [2:0]              m_rows;
    int errors = 0, tests = 0, failed_tests = 0, test_start = 0, cycles = 0, post_over = 0;
    int unsigned pick;

    `include "tb_tetris_model.svh"

    tetris_core u_tetris_core
    (
        .clk(clk), .rst(rst), .move_left(move_left), .move_right(move_right), .rotate(rotate),
        .drop_tick(drop_tick), .next_type(next_type), .board(board), .piece_type(piece_type),
        .piece_rot(piece_rot), .piece_x(piece_x), .piece_y(piece_y), .locked(locked),
        .rows_cleared(rows_cleared), .game_over(game_over)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // model advances on the inputs held across the rising edge
    always @(posedge clk)
    begin
        if (rst)
        begin
            m_board  = '0;
            m_type   = 0;
            m_rot    = 0;
            m_x      = 140;
            m_y      = 0;
            m_locked = 0;
            m_rows   = 0;
            m_go     = 0;
        end
        else
            predict_step(m_board, m_type, m_rot, m_x, m_y, m_locked, m_rows, m_go,
                         drop_tick, rotate, move_left, move_right, next_type);
    end

    always @(negedge clk)
    begin
        if (!rst)
        begin
            check_board("board", board, m_board);
            check_type("piece_type", piece_type, m_type);
            check_rot("piece_rot", piece_rot, m_rot);
            check_pos("piece_x", piece_x, m_x);
            check_pos("piece_y", piece_y, m_y);
            check_bit("locked", locked, m_locked);
            check_count("rows_cleared", rows_cleared, m_rows);
            check_bit("game_over", game_over, m_go);
        end
    end

    initial
    begin
        forever
        begin
            @(posedge clk);
            cycles++;
            if (cycles >= cycle_limit)
            begin
                $display("timeout: run still going after %0d cycles", cycles);
                $display("RESULT: FAIL");
                $finish;
            end
        end
    end

    task automatic strobe(input logic [3:0] s);
        @(negedge clk);
        {drop_tick, rotate, move_left, move_right} = s;
        @(negedge clk);
        {drop_tick, rotate, move_left, move_right} = '0; // result is visible here
    endtask

    task automatic drop_until_lock();
        do
            strobe(4'b1000);
        while (!locked);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors != test_start)
            failed_tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - test_start);
        test_start = errors;
    endtask

    initial
    begin
        pick = $urandom(27307);
        rst = 1'b1;
        {move_left, move_right, rotate, drop_tick} = '0;
        next_type = 0;
        prev_drop = 0;
        apply_reset();
        check_board("board", board, '0);
        check_type("piece_type", piece_type, 0);
        check_rot("piece_rot", piece_rot, 0);
        check_pos("piece_x", piece_x, tetris_pkg::spawn_x);
        check_pos("piece_y", piece_y, tetris_pkg::spawn_y);
        check_bit("locked", locked, 0);
        check_count("rows_cleared", rows_cleared, 3'd0);
        check_bit("game_over", game_over, 0);
        end_test("reset state");

        repeat (5) strobe(4'b0010);
        check_pos("piece_x", piece_x, tetris_pkg::margin_px);
        repeat (10) strobe(4'b0001);
        check_pos("piece_x", piece_x, tetris_pkg::margin_px + 6 * tetris_pkg::cell_px);
        end_test("walls");

        strobe(4'b0100);
        check_rot("piece_rot", piece_rot, 1);
        repeat (10) strobe(4'b0010);
        check_pos("piece_x", piece_x, 40); // vertical I sits in frame column 2
        strobe(4'b0100);
        check_rot("piece_rot", piece_rot, 1);
        end_test("rotation");

        next_type = 1;
        drop_until_lock();
        exp_board = '0;
        exp_board[190] = 1'b1;
        exp_board[200] = 1'b1;
        exp_board[210] = 1'b1;
        exp_board[220] = 1'b1;
        check_board("board", board, exp_board);
        check_type("piece_type", piece_type, 1);
        check_pos("piece_y", piece_y, tetris_pkg::spawn_y);
        end_test("lock");

        apply_reset();
        next_type = 0;
        repeat (3) strobe(4'b0010);
        drop_until_lock();
        next_type = 1;
        strobe(4'b0001);
        drop_until_lock();
        repeat (4) strobe(4'b0001);
        next_type = 0;
        drop_until_lock();
        check_count("rows_cleared", rows_cleared, 3'd1);
        exp_board = '0;
        exp_board[228] = 1'b1;
        exp_board[229] = 1'b1;
        check_board("board", board, exp_board);
        end_test("line clear");

        repeat (3) strobe(4'b0001);
        check_pos("piece_x", piece_x, 200);
        repeat (19) strobe(4'b1000);
        check_pos("piece_y", piece_y, 380);
        strobe(4'b0100);
        check_rot("piece_rot", piece_rot, 0); // upright I would cover the settled cell in row 22
        end_test("rotation onto settled cells");

        for (int i = 0; i < random_cycles && post_over < 60; i++)
        begin
            @(negedge clk);
            pick       = $urandom % 8;
            drop_tick  = pick < 4 && !prev_drop; // never two drops in a row
            rotate     = pick == 4;
            move_left  = pick == 5;
            move_right = pick == 6;
            prev_drop  = drop_tick;
            next_type  = $urandom % 7;
            if (game_over)
                post_over++;
        end
        @(negedge clk);
        {move_left, move_right, rotate, drop_tick} = '0;
        if (!game_over)
        begin
            errors++;
            $display("random run ended without reaching game over");
        end
        end_test("random run and game over");

        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests, failed_tests, errors, u_tetris_core.u_asserts.assert_fails);
        if (errors == 0 && u_tetris_core.u_asserts.assert_fails == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: tb/tetris_core_asserts.sv
`timescale 1ns/1ns

module tetris_core_asserts
(
    input logic             clk,
    input logic             rst,
    input logic             locked,
    input logic [2:0]       rows_cleared,
    input tetris_pkg::pos_t piece_x,
    input logic             game_over
);

    int assert_fails = 0;

    a_locked_pulse: assert property (@(posedge clk) disable iff (rst) locked |=> !locked)
    else
    begin
        $error("locked stayed high for more than one cycle");
        assert_fails++;
    end

    a_rows_idle: assert property (@(posedge clk) disable iff (rst) !locked |-> rows_cleared == 0)
    else
    begin
        $error("rows_cleared nonzero without locked");
        assert_fails++;
    end

    // the 4x4 frame may hang two cells past the left wall
    a_x_range: assert property (@(posedge clk) disable iff (rst)
        piece_x >= tetris_pkg::margin_px - 2 * tetris_pkg::cell_px && piece_x <= 280)
    else
    begin
        $error("piece_x out of range");
        assert_fails++;
    end

    a_over_sticky: assert property (@(posedge clk) $fell(game_over) |-> $past(rst))
    else
    begin
        $error("game_over fell without reset");
        assert_fails++;
    end

endmodule

bind tetris_core tetris_core_asserts u_asserts
(
    .clk(clk), .rst(rst), .locked(locked), .rows_cleared(rows_cleared),
    .piece_x(piece_x), .game_over(game_over)
);

// File: verilog.f
+incdir+tb
common/tetris_pkg.sv
collision/saved_boundary_check.sv
src/piece_edges.sv
src/saved_board.sv
src/drop_control.sv
src/tetris_core.sv
tb/tetris_core_asserts.sv
tb/tb_tetris_core.sv
